//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_wup_write_upsizer -o tb_sim

output=$(./obj_dir/tb_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "TEST PASS"; then
    exit 0
fi
exit 1

//--- src/wup_axi_pkg.sv
`default_nettype none

package wup_axi_pkg;

    // Common fields
    localparam int id_width    = 4;
    localparam int addr_width  = 32;
    localparam int len_width   = 8;
    localparam int size_width  = 3;
    localparam int burst_width = 2;
    localparam int resp_width  = 2;

    // Data paths, 32-bit subordinate side and 64-bit manager side
    localparam int narrow_data_width = 32;
    localparam int wide_data_width   = 64;
    localparam int narrow_strb_width = narrow_data_width / 8;
    localparam int wide_strb_width   = wide_data_width / 8;

    localparam logic [burst_width-1:0] burst_fixed = 2'b00;
    localparam logic [burst_width-1:0] burst_incr  = 2'b01;

    // Beat size codes
    localparam logic [size_width-1:0] narrow_size_code = 3'd2;
    localparam logic [size_width-1:0] wide_size_code   = 3'd3;

endpackage

`default_nettype wire

//--- src/wup_beat_packer.sv
`timescale 1ns/10ps
`default_nettype none

module wup_beat_packer
    import wup_axi_pkg::*, wup_conv_pkg::*;
(
    input  logic                         aclk,
    input  logic                         aresetn,

    input  logic                         cmd_valid,
    output logic                         cmd_ready,
    input  logic                         cmd_mode,
    input  logic                         cmd_lane,
    input  logic [len_width:0]           cmd_beats,

    input  logic                         in_valid,
    output logic                         in_ready,
    input  logic [narrow_data_width-1:0] in_data,
    input  logic [narrow_strb_width-1:0] in_strb,

    output logic                         out_valid,
    input  logic                         out_ready,
    output logic [wide_data_width-1:0]   out_data,
    output logic [wide_strb_width-1:0]   out_strb,
    output logic                         out_last
);

    // Current burst
    logic               active;
    logic               mode_r;
    logic               lane_r;
    logic [len_width:0] beats_left;

    wide_beat_u acc_data;
    wide_beat_u merged_data;
    wide_strb_u acc_strb;
    wide_strb_u merged_strb;

    logic last_beat;
    logic emit;
    logic take_cmd;
    logic take_beat;

    // Accumulator with the incoming beat dropped into its lane
    always_comb begin
        merged_data              = acc_data;
        merged_data.lane[lane_r] = in_data;
        merged_strb              = acc_strb;
        merged_strb.lane[lane_r] = in_strb;
    end

    assign last_beat = (beats_left == 1);

    // Place mode sends every beat, pack mode waits for the top lane
    assign emit = (mode_r == mode_place) || (lane_r == 1'(lane_count - 1)) || last_beat;

    assign cmd_ready = ~active;
    assign take_cmd  = cmd_valid & cmd_ready;
    assign in_ready  = active & (~emit | out_ready);
    assign take_beat = in_valid & in_ready;

    assign out_valid = active & in_valid & emit;
    assign out_data  = merged_data.word;
    assign out_strb  = merged_strb.word;
    assign out_last  = last_beat;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            active     <= 1'b0;
            mode_r     <= mode_pack;
            lane_r     <= 1'b0;
            beats_left <= '0;
        end else if (take_cmd) begin
            active     <= 1'b1;
            mode_r     <= cmd_mode;
            lane_r     <= cmd_lane;
            beats_left <= cmd_beats;
        end else if (take_beat) begin
            beats_left <= beats_left - 1'b1;
            if (last_beat) begin
                active <= 1'b0;
            end
            if (mode_r == mode_pack) begin
                lane_r <= lane_r + 1'b1;
            end
        end
    end

    // Lanes not written in a wide beat stay zero
    always_ff @(posedge aclk) begin
        if (take_cmd) begin
            acc_data <= '0;
            acc_strb <= '0;
        end else if (take_beat) begin
            if (emit) begin
                acc_data <= '0;
                acc_strb <= '0;
            end else begin
                acc_data <= merged_data;
                acc_strb <= merged_strb;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/wup_burst_planner.sv
`timescale 1ns/10ps
`default_nettype none

module wup_burst_planner
    import wup_axi_pkg::*, wup_conv_pkg::*;
(
    input  logic                   aclk,
    input  logic                   aresetn,

    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  logic [id_width-1:0]    aw_id,
    input  logic [addr_width-1:0]  aw_addr,
    input  logic [len_width-1:0]   aw_len,
    input  logic [burst_width-1:0] aw_burst,

    output logic                   m_awvalid,
    input  logic                   m_awready,
    output logic [id_width-1:0]    m_awid,
    output logic [addr_width-1:0]  m_awaddr,
    output logic [len_width-1:0]   m_awlen,
    output logic [size_width-1:0]  m_awsize,
    output logic [burst_width-1:0] m_awburst,

    output logic                   cmd_valid,
    input  logic                   cmd_ready,
    output logic                   cmd_mode,
    output logic                   cmd_lane,
    output logic [len_width:0]     cmd_beats
);

    // Command queue storage, depth is a power of two
    logic                                 mode_q  [cmd_queue_depth];
    logic                                 lane_q  [cmd_queue_depth];
    logic [len_width:0]                   beats_q [cmd_queue_depth];
    logic [$clog2(cmd_queue_depth)-1:0]   wr_ptr;
    logic [$clog2(cmd_queue_depth)-1:0]   rd_ptr;
    logic [$clog2(cmd_queue_depth+1)-1:0] q_count;
    logic                                 q_full;

    logic                  aw_push;
    logic                  cmd_pop;
    logic                  is_fixed;
    logic                  start_lane;
    logic [len_width:0]    beats;
    logic [len_width:0]    span;
    logic [len_width-1:0]  wide_len;

    assign q_full  = (q_count == cmd_queue_depth);
    assign aw_ready = (~m_awvalid | m_awready) & ~q_full;
    assign aw_push = aw_valid & aw_ready;
    assign cmd_pop = cmd_valid & cmd_ready;

    // Length and lane of the outgoing burst
    assign is_fixed   = (aw_burst == burst_fixed);
    assign start_lane = aw_addr[lane_sel_bit];
    assign beats      = {1'b0, aw_len} + 1'b1;
    assign span       = beats + (len_width + 1)'(start_lane) + 1'b1;
    assign wide_len   = is_fixed ? aw_len : span[len_width:1] - 1'b1;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            m_awvalid <= 1'b0;
        end else if (aw_push) begin
            m_awvalid <= 1'b1;
        end else if (m_awready) begin
            m_awvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_push) begin
            m_awid    <= aw_id;
            m_awaddr  <= aw_addr;
            m_awlen   <= wide_len;
            m_awsize  <= is_fixed ? narrow_size_code : wide_size_code;
            m_awburst <= aw_burst;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (aw_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (cmd_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (aw_push && !cmd_pop) begin
                q_count <= q_count + 1'b1;
            end else if (cmd_pop && !aw_push) begin
                q_count <= q_count - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_push) begin
            mode_q[wr_ptr]  <= is_fixed ? mode_place : mode_pack;
            lane_q[wr_ptr]  <= start_lane;
            beats_q[wr_ptr] <= beats;
        end
    end

    assign cmd_valid = (q_count != 0);
    assign cmd_mode  = mode_q[rd_ptr];
    assign cmd_lane  = lane_q[rd_ptr];
    assign cmd_beats = beats_q[rd_ptr];

endmodule

`default_nettype wire

//--- src/wup_conv_pkg.sv
`default_nettype none

package wup_conv_pkg;

    import wup_axi_pkg::*;

    // Narrow lanes in one wide beat
    localparam int lane_count   = wide_data_width / narrow_data_width;
    localparam int lane_sel_bit = 2;

    // Command mode, pack for INCR and place for FIXED
    localparam logic mode_pack  = 1'b0;
    localparam logic mode_place = 1'b1;

    localparam int cmd_queue_depth = 2;

    // Wide data beat, whole word or per narrow lane
    typedef union packed {
        logic [wide_data_width-1:0]                        word;
        logic [lane_count-1:0][narrow_data_width-1:0]      lane;
    } wide_beat_u;

    // Same view for the strobes
    typedef union packed {
        logic [wide_strb_width-1:0]                        word;
        logic [lane_count-1:0][narrow_strb_width-1:0]      lane;
    } wide_strb_u;

endpackage

`default_nettype wire

//--- src/wup_skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module wup_skid_buffer #(
    parameter int data_width = 8
) (
    input  logic                  aclk,
    input  logic                  aresetn,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [data_width-1:0] in_data,

    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [data_width-1:0] out_data
);

    logic                  skid_valid;
    logic [data_width-1:0] skid_data;
    logic                  push;
    logic                  load_out;
    logic                  skid_valid_d;

    assign push = in_valid & in_ready;

    // Output register is free when empty or being drained
    assign load_out = ~out_valid | out_ready;

    always_comb begin
        if (load_out) begin
            skid_valid_d = 1'b0;
        end else begin
            skid_valid_d = skid_valid | push;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            if (load_out) begin
                out_valid <= skid_valid | push;
            end
            skid_valid <= skid_valid_d;
            // Ready falls only once the skid entry holds a word
            in_ready   <= ~skid_valid_d;
        end
    end

    always_ff @(posedge aclk) begin
        if (load_out) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (push && !load_out) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- src/wup_write_upsizer.sv
`timescale 1ns/10ps
`default_nettype none

module wup_write_upsizer
    import wup_axi_pkg::*;
(
    input  logic                         aclk,
    input  logic                         aresetn,

    input  logic [id_width-1:0]          s_axi_awid,
    input  logic [addr_width-1:0]        s_axi_awaddr,
    input  logic [len_width-1:0]         s_axi_awlen,
    input  logic [burst_width-1:0]       s_axi_awburst,
    input  logic                         s_axi_awvalid,
    output logic                         s_axi_awready,

    input  logic [narrow_data_width-1:0] s_axi_wdata,
    input  logic [narrow_strb_width-1:0] s_axi_wstrb,
    input  logic                         s_axi_wvalid,
    output logic                         s_axi_wready,

    output logic [id_width-1:0]          s_axi_bid,
    output logic [resp_width-1:0]        s_axi_bresp,
    output logic                         s_axi_bvalid,
    input  logic                         s_axi_bready,

    output logic [id_width-1:0]          m_axi_awid,
    output logic [addr_width-1:0]        m_axi_awaddr,
    output logic [len_width-1:0]         m_axi_awlen,
    output logic [size_width-1:0]        m_axi_awsize,
    output logic [burst_width-1:0]       m_axi_awburst,
    output logic                         m_axi_awvalid,
    input  logic                         m_axi_awready,

    output logic [wide_data_width-1:0]   m_axi_wdata,
    output logic [wide_strb_width-1:0]   m_axi_wstrb,
    output logic                         m_axi_wlast,
    output logic                         m_axi_wvalid,
    input  logic                         m_axi_wready,

    input  logic [id_width-1:0]          m_axi_bid,
    input  logic [resp_width-1:0]        m_axi_bresp,
    input  logic                         m_axi_bvalid,
    output logic                         m_axi_bready
);

    logic [id_width+addr_width+len_width+burst_width-1:0] aw_in_payload;
    logic [id_width+addr_width+len_width+burst_width-1:0] aw_out_payload;
    logic                         aw_valid;
    logic                         aw_ready;
    logic [id_width-1:0]          aw_id;
    logic [addr_width-1:0]        aw_addr;
    logic [len_width-1:0]         aw_len;
    logic [burst_width-1:0]       aw_burst;

    logic [narrow_data_width+narrow_strb_width-1:0] w_in_payload;
    logic [narrow_data_width+narrow_strb_width-1:0] w_out_payload;
    logic                         w_valid;
    logic                         w_ready;
    logic [narrow_data_width-1:0] w_data;
    logic [narrow_strb_width-1:0] w_strb;

    logic                         cmd_valid;
    logic                         cmd_ready;
    logic                         cmd_mode;
    logic                         cmd_lane;
    logic [len_width:0]           cmd_beats;

    logic [wide_data_width+wide_strb_width:0] pk_payload;
    logic [wide_data_width+wide_strb_width:0] m_w_payload;
    logic                         pk_valid;
    logic                         pk_ready;
    logic [wide_data_width-1:0]   pk_data;
    logic [wide_strb_width-1:0]   pk_strb;
    logic                         pk_last;

    assign aw_in_payload = {s_axi_awid, s_axi_awaddr, s_axi_awlen, s_axi_awburst};
    assign {aw_id, aw_addr, aw_len, aw_burst} = aw_out_payload;
    assign w_in_payload  = {s_axi_wdata, s_axi_wstrb};
    assign {w_data, w_strb} = w_out_payload;
    assign pk_payload    = {pk_data, pk_strb, pk_last};
    assign {m_axi_wdata, m_axi_wstrb, m_axi_wlast} = m_w_payload;

    // Responses need no conversion
    assign s_axi_bid    = m_axi_bid;
    assign s_axi_bresp  = m_axi_bresp;
    assign s_axi_bvalid = m_axi_bvalid;
    assign m_axi_bready = s_axi_bready;

    wup_skid_buffer #(
        .data_width (id_width + addr_width + len_width + burst_width)
    ) u_aw_in (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (s_axi_awvalid),
        .in_ready  (s_axi_awready),
        .in_data   (aw_in_payload),
        .out_valid (aw_valid),
        .out_ready (aw_ready),
        .out_data  (aw_out_payload)
    );

    wup_skid_buffer #(
        .data_width (narrow_data_width + narrow_strb_width)
    ) u_w_in (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (s_axi_wvalid),
        .in_ready  (s_axi_wready),
        .in_data   (w_in_payload),
        .out_valid (w_valid),
        .out_ready (w_ready),
        .out_data  (w_out_payload)
    );

    wup_burst_planner u_planner (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw_id     (aw_id),
        .aw_addr   (aw_addr),
        .aw_len    (aw_len),
        .aw_burst  (aw_burst),
        .m_awvalid (m_axi_awvalid),
        .m_awready (m_axi_awready),
        .m_awid    (m_axi_awid),
        .m_awaddr  (m_axi_awaddr),
        .m_awlen   (m_axi_awlen),
        .m_awsize  (m_axi_awsize),
        .m_awburst (m_axi_awburst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_mode  (cmd_mode),
        .cmd_lane  (cmd_lane),
        .cmd_beats (cmd_beats)
    );

    wup_beat_packer u_packer (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_mode  (cmd_mode),
        .cmd_lane  (cmd_lane),
        .cmd_beats (cmd_beats),
        .in_valid  (w_valid),
        .in_ready  (w_ready),
        .in_data   (w_data),
        .in_strb   (w_strb),
        .out_valid (pk_valid),
        .out_ready (pk_ready),
        .out_data  (pk_data),
        .out_strb  (pk_strb),
        .out_last  (pk_last)
    );

    wup_skid_buffer #(
        .data_width (wide_data_width + wide_strb_width + 1)
    ) u_w_out (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (pk_valid),
        .in_ready  (pk_ready),
        .in_data   (pk_payload),
        .out_valid (m_axi_wvalid),
        .out_ready (m_axi_wready),
        .out_data  (m_w_payload)
    );

endmodule

`default_nettype wire

//--- verif/tb_wup_write_upsizer.sv
`timescale 1ns/10ps
`default_nettype none

module tb_wup_write_upsizer
    import wup_axi_pkg::*;
();

    localparam int directed_bursts = 5;
    localparam int random_bursts   = 24;
    localparam int timeout_cycles  = 40 * (directed_bursts + random_bursts) + 200;

    logic                         aclk = 1'b0;
    logic                         aresetn;
    logic [id_width-1:0]          s_axi_awid;
    logic [addr_width-1:0]        s_axi_awaddr;
    logic [len_width-1:0]         s_axi_awlen;
    logic [burst_width-1:0]       s_axi_awburst;
    logic                         s_axi_awvalid;
    logic                         s_axi_awready;
    logic [narrow_data_width-1:0] s_axi_wdata;
    logic [narrow_strb_width-1:0] s_axi_wstrb;
    logic                         s_axi_wvalid;
    logic                         s_axi_wready;
    logic [id_width-1:0]          s_axi_bid;
    logic [resp_width-1:0]        s_axi_bresp;
    logic                         s_axi_bvalid;
    logic                         s_axi_bready;
    logic [id_width-1:0]          m_axi_awid;
    logic [addr_width-1:0]        m_axi_awaddr;
    logic [len_width-1:0]         m_axi_awlen;
    logic [size_width-1:0]        m_axi_awsize;
    logic [burst_width-1:0]       m_axi_awburst;
    logic                         m_axi_awvalid;
    logic                         m_axi_awready;
    logic [wide_data_width-1:0]   m_axi_wdata;
    logic [wide_strb_width-1:0]   m_axi_wstrb;
    logic                         m_axi_wlast;
    logic                         m_axi_wvalid;
    logic                         m_axi_wready;
    logic [id_width-1:0]          m_axi_bid;
    logic [resp_width-1:0]        m_axi_bresp;
    logic                         m_axi_bvalid;
    logic                         m_axi_bready;

    logic [31:0] lfsr_state = 32'd71010;
    int          cycle_count = 0;

    // Bursts still to be sent on the narrow side
    logic [id_width-1:0]          req_id[$];
    logic [addr_width-1:0]        req_addr[$];
    logic [len_width-1:0]         req_len[$];
    logic [burst_width-1:0]       req_burst[$];
    logic [narrow_data_width-1:0] req_wdata[$];

    // Expected traffic on the wide side
    logic [id_width-1:0]          exp_awid[$];
    logic [addr_width-1:0]        exp_awaddr[$];
    logic [len_width-1:0]         exp_awlen[$];
    logic [size_width-1:0]        exp_awsize[$];
    logic [burst_width-1:0]       exp_awburst[$];
    logic [wide_data_width-1:0]   exp_wdata[$];
    logic [wide_strb_width-1:0]   exp_wstrb[$];
    logic                         exp_wlast[$];

    wup_write_upsizer u_dut (.*);

    initial begin
        forever #10 aclk = ~aclk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] expected);
        abort_run($sformatf("Error at %0d ns: %s is %h, expected %h", $time, what, got,
                            expected));
    endtask

    task automatic plan_burst(input logic fixed, input int beats, input logic lane);
        logic [wide_data_width-1:0]   acc_data;
        logic [wide_strb_width-1:0]   acc_strb;
        logic [narrow_data_width-1:0] word;
        logic [addr_width-1:0]        addr;
        logic [id_width-1:0]          id;
        int                           pos;
        id   = id_width'(rand_bits(id_width));
        addr = addr_width'({rand_bits(addr_width - 3), lane, 2'b00});
        req_id.push_back(id);
        req_addr.push_back(addr);
        req_len.push_back(len_width'(beats - 1));
        req_burst.push_back(fixed ? burst_fixed : burst_incr);
        exp_awid.push_back(id);
        exp_awaddr.push_back(addr);
        exp_awburst.push_back(fixed ? burst_fixed : burst_incr);
        if (fixed) begin
            exp_awlen.push_back(len_width'(beats - 1));
            exp_awsize.push_back(3'd2);
        end else begin
            // Start lane plus narrow beats rounded up to wide beats
            exp_awlen.push_back(len_width'((int'(lane) + beats + 1) / 2 - 1));
            exp_awsize.push_back(3'd3);
        end
        acc_data = '0;
        acc_strb = '0;
        for (int k = 0; k < beats; k++) begin
            word = rand_bits(narrow_data_width);
            req_wdata.push_back(word);
            pos = fixed ? int'(lane) : (int'(lane) + k) % 2;
            acc_data[pos*narrow_data_width +: narrow_data_width] = word;
            acc_strb[pos*narrow_strb_width +: narrow_strb_width] = '1;
            if (fixed || pos == 1 || k == beats - 1) begin
                exp_wdata.push_back(acc_data);
                exp_wstrb.push_back(acc_strb);
                exp_wlast.push_back(k == beats - 1);
                acc_data = '0;
                acc_strb = '0;
            end
        end
    endtask

    task automatic drive_aw_bursts();
        logic accepted;
        while (req_id.size() != 0) begin
            s_axi_awid    = req_id.pop_front();
            s_axi_awaddr  = req_addr.pop_front();
            s_axi_awlen   = req_len.pop_front();
            s_axi_awburst = req_burst.pop_front();
            s_axi_awvalid = 1'b1;
            accepted      = 1'b0;
            while (!accepted) begin
                @(negedge aclk);
                accepted = s_axi_awready;
                @(posedge aclk);
                #1;
            end
            s_axi_awvalid = 1'b0;
            if (rand_bits(2) == 0) begin
                @(posedge aclk);
                #1;
            end
        end
    endtask

    task automatic drive_w_beats();
        logic accepted;
        while (req_wdata.size() != 0) begin
            s_axi_wdata  = req_wdata.pop_front();
            s_axi_wstrb  = '1;
            s_axi_wvalid = 1'b1;
            accepted     = 1'b0;
            while (!accepted) begin
                @(negedge aclk);
                accepted = s_axi_wready;
                @(posedge aclk);
                #1;
            end
            s_axi_wvalid = 1'b0;
            if (rand_bits(2) == 0) begin
                @(posedge aclk);
                #1;
            end
        end
    endtask

    task automatic check_aw();
        if (exp_awid.size() == 0) begin
            abort_run("Manager AW handshake seen with no burst left to expect");
        end else begin
            assert (m_axi_awid == exp_awid[0])
                else report_mismatch("m_axi_awid", 64'(m_axi_awid), 64'(exp_awid[0]));
            assert (m_axi_awaddr == exp_awaddr[0])
                else report_mismatch("m_axi_awaddr", 64'(m_axi_awaddr), 64'(exp_awaddr[0]));
            assert (m_axi_awlen == exp_awlen[0])
                else report_mismatch("m_axi_awlen", 64'(m_axi_awlen), 64'(exp_awlen[0]));
            assert (m_axi_awsize == exp_awsize[0])
                else report_mismatch("m_axi_awsize", 64'(m_axi_awsize), 64'(exp_awsize[0]));
            assert (m_axi_awburst == exp_awburst[0])
                else report_mismatch("m_axi_awburst", 64'(m_axi_awburst), 64'(exp_awburst[0]));
            void'(exp_awid.pop_front());
            void'(exp_awaddr.pop_front());
            void'(exp_awlen.pop_front());
            void'(exp_awsize.pop_front());
            void'(exp_awburst.pop_front());
        end
    endtask

    task automatic check_w();
        if (exp_wdata.size() == 0) begin
            abort_run("Manager W handshake seen with no wide beat left to expect");
        end else begin
            assert (m_axi_wdata == exp_wdata[0])
                else report_mismatch("m_axi_wdata", m_axi_wdata, exp_wdata[0]);
            assert (m_axi_wstrb == exp_wstrb[0])
                else report_mismatch("m_axi_wstrb", 64'(m_axi_wstrb), 64'(exp_wstrb[0]));
            assert (m_axi_wlast == exp_wlast[0])
                else report_mismatch("m_axi_wlast", 64'(m_axi_wlast), 64'(exp_wlast[0]));
            void'(exp_wdata.pop_front());
            void'(exp_wstrb.pop_front());
            void'(exp_wlast.pop_front());
        end
    endtask

    // Handshakes sampled mid-cycle where valid and ready are settled
    always @(negedge aclk) begin
        if (!aresetn) begin
            assert (!m_axi_awvalid && !m_axi_wvalid && !s_axi_awready && !s_axi_wready)
                else abort_run($sformatf("Error at %0d ns: valid or ready high in reset", $time));
        end else begin
            if (m_axi_awvalid && m_axi_awready) begin
                check_aw();
            end
            if (m_axi_wvalid && m_axi_wready) begin
                check_w();
            end
        end
        assert (s_axi_bid == m_axi_bid && s_axi_bresp == m_axi_bresp
                && s_axi_bvalid == m_axi_bvalid && m_axi_bready == s_axi_bready)
            else abort_run($sformatf("Error at %0d ns: B channel not passed through", $time));
    end

    // Random stalls on the wide side and random responses
    always @(posedge aclk) begin
        #1;
        m_axi_awready = (rand_bits(2) != 0);
        m_axi_wready  = (rand_bits(2) != 0);
        m_axi_bid     = id_width'(rand_bits(id_width));
        m_axi_bresp   = resp_width'(rand_bits(resp_width));
        m_axi_bvalid  = (rand_bits(1) != 0);
        s_axi_bready  = (rand_bits(1) != 0);
    end

    always @(posedge aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            abort_run($sformatf("Timeout: traffic did not drain within %0d cycles",
                                timeout_cycles));
        end
    end

    initial begin
        aresetn       = 1'b0;
        s_axi_awid    = '0;
        s_axi_awaddr  = '0;
        s_axi_awlen   = '0;
        s_axi_awburst = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        m_axi_awready = 1'b0;
        m_axi_wready  = 1'b0;
        m_axi_bid     = '0;
        m_axi_bresp   = '0;
        m_axi_bvalid  = 1'b0;

        plan_burst(1'b0, 4, 1'b0);
        // Odd start lane then odd length
        plan_burst(1'b0, 4, 1'b1);
        plan_burst(1'b0, 3, 1'b0);
        plan_burst(1'b1, 3, 1'b1);
        plan_burst(1'b1, 2, 1'b0);
        for (int i = 0; i < random_bursts; i++) begin
            plan_burst(rand_bits(2) == 0, int'(rand_bits(3)) + 1, rand_bits(1) != 0);
        end

        repeat (10) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(negedge aclk);
        assert (!m_axi_awvalid && !m_axi_wvalid && !s_axi_awready && !s_axi_wready)
            else abort_run($sformatf("Error at %0d ns: output high right after reset", $time));
        @(negedge aclk);
        assert (s_axi_awready && s_axi_wready)
            else abort_run($sformatf("Error at %0d ns: readies low after reset", $time));
        @(posedge aclk);
        #1;

        fork
            drive_aw_bursts();
            drive_w_beats();
        join
        while (exp_awid.size() != 0 || exp_wdata.size() != 0) begin
            @(posedge aclk);
        end
        // A few more cycles to catch extra beats
        repeat (5) @(posedge aclk);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
src/wup_axi_pkg.sv
src/wup_conv_pkg.sv
src/wup_skid_buffer.sv
src/wup_burst_planner.sv
src/wup_beat_packer.sv
src/wup_write_upsizer.sv
verif/tb_wup_write_upsizer.sv
